/* hw/exu_pkg.sv */
// RV64I execute slice definitions
`default_nettype none

package exu_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [2:0]  br_op_t;
  typedef logic [2:0]  mem_op_t;
  typedef logic [1:0]  src_b_t;

  // Issue FIFO size, a power of two of at least 2
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

  localparam inst_t INST_EBREAK = 32'h0010_0073;

  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  localparam alu_op_t ALU_COPYB = 4'd10;

  // Unsigned compares reuse LT/GE with br_unsigned set
  localparam br_op_t BR_NONE = 3'd0;
  localparam br_op_t BR_JAL  = 3'd1;
  localparam br_op_t BR_JALR = 3'd2;
  localparam br_op_t BR_EQ   = 3'd3;
  localparam br_op_t BR_NE   = 3'd4;
  localparam br_op_t BR_LT   = 3'd5;
  localparam br_op_t BR_GE   = 3'd6;
  localparam br_op_t BR_LTU  = BR_LT;
  localparam br_op_t BR_GEU  = BR_GE;

  localparam mem_op_t MEM_LB  = 3'd0;
  localparam mem_op_t MEM_LBU = 3'd1;
  localparam mem_op_t MEM_LH  = 3'd2;
  localparam mem_op_t MEM_LHU = 3'd3;
  localparam mem_op_t MEM_LW  = 3'd4;
  localparam mem_op_t MEM_LWU = 3'd5;
  localparam mem_op_t MEM_LD  = 3'd6;

  localparam src_b_t SRC_B_RS2  = 2'd0;
  localparam src_b_t SRC_B_IMM  = 2'd1;
  localparam src_b_t SRC_B_FOUR = 2'd2;

  typedef struct packed {
    alu_op_t alu_op;
    br_op_t  br_op;
    logic    br_unsigned;
    logic    src_a_pc;
    src_b_t  src_b;
    logic    word_cut;
    logic    mem_to_reg;
    mem_op_t mem_op;
    logic    sel_csr;
    logic    csr_write;
    logic    halt;
    logic    illegal;
  } ctl_t;

  typedef struct packed {
    ctl_t  ctl;
    xlen_t pc;
    xlen_t rs1;
    xlen_t rs2;
    xlen_t imm;
    xlen_t rdata;
  } issue_entry_t;

  typedef struct packed {
    xlen_t gpr_wdata;
    xlen_t next_pc;
    xlen_t csr_wdata;
    logic  csr_we;
    logic  halt;
    logic  illegal;
  } exu_result_t;

endpackage

`default_nettype wire

/* hw/idu_decode.sv */
// Instruction decoder
`default_nettype none

module idu_decode (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_inst_valid,
  input  wire exu_pkg::inst_t    i_inst,
  input  wire exu_pkg::xlen_t    i_pc,
  input  wire exu_pkg::xlen_t    i_rs1,
  input  wire exu_pkg::xlen_t    i_rs2,
  input  wire exu_pkg::xlen_t    i_rdata,
  output logic                   o_push,
  output exu_pkg::issue_entry_t  o_entry
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic rr_legal;
  logic f3_word;
  logic sh6_ok;
  exu_pkg::xlen_t imm_i;
  exu_pkg::xlen_t imm_u;
  exu_pkg::xlen_t imm_j;
  exu_pkg::xlen_t imm_b;
  exu_pkg::xlen_t imm;
  exu_pkg::ctl_t ctl;

  // Shared by OP, OP-IMM and the W forms
  function automatic exu_pkg::alu_op_t rr_alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
      3'b001:  return exu_pkg::ALU_SLL;
      3'b010:  return exu_pkg::ALU_SLT;
      3'b011:  return exu_pkg::ALU_SLTU;
      3'b100:  return exu_pkg::ALU_XOR;
      3'b101:  return alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
      3'b110:  return exu_pkg::ALU_OR;
      default: return exu_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

  // funct7 of 0100000 only for SUB and SRA
  assign rr_legal = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign f3_word  = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
  assign sh6_ok   = (i_inst[31:26] == 6'b000000) ||
                    (i_inst[31:26] == 6'b010000 && funct3 == 3'b101);

  always_comb begin
    ctl        = '0;
    ctl.alu_op = exu_pkg::ALU_ADD;
    ctl.br_op  = exu_pkg::BR_NONE;
    ctl.src_b  = exu_pkg::SRC_B_RS2;
    ctl.mem_op = exu_pkg::MEM_LD;
    imm        = imm_i;
    case (opcode)
      exu_pkg::OPC_LUI: begin
        ctl.alu_op = exu_pkg::ALU_COPYB;
        ctl.src_b  = exu_pkg::SRC_B_IMM;
        imm        = imm_u;
      end
      exu_pkg::OPC_AUIPC: begin
        ctl.src_a_pc = 1'b1;
        ctl.src_b    = exu_pkg::SRC_B_IMM;
        imm          = imm_u;
      end
      exu_pkg::OPC_JAL: begin
        ctl.br_op    = exu_pkg::BR_JAL;
        ctl.src_a_pc = 1'b1;
        ctl.src_b    = exu_pkg::SRC_B_FOUR;
        imm          = imm_j;
      end
      exu_pkg::OPC_JALR: begin
        ctl.br_op    = exu_pkg::BR_JALR;
        ctl.src_a_pc = 1'b1;
        ctl.src_b    = exu_pkg::SRC_B_FOUR;
        ctl.illegal  = (funct3 != 3'b000);
      end
      exu_pkg::OPC_BRANCH: begin
        ctl.alu_op = exu_pkg::ALU_SUB;
        imm        = imm_b;
        case (funct3)
          3'b000:  ctl.br_op = exu_pkg::BR_EQ;
          3'b001:  ctl.br_op = exu_pkg::BR_NE;
          3'b100:  ctl.br_op = exu_pkg::BR_LT;
          3'b101:  ctl.br_op = exu_pkg::BR_GE;
          3'b110: begin
            ctl.br_op       = exu_pkg::BR_LTU;
            ctl.br_unsigned = 1'b1;
          end
          3'b111: begin
            ctl.br_op       = exu_pkg::BR_GEU;
            ctl.br_unsigned = 1'b1;
          end
          default: ctl.illegal = 1'b1;
        endcase
      end
      exu_pkg::OPC_LOAD: begin
        ctl.mem_to_reg = 1'b1;
        ctl.src_b      = exu_pkg::SRC_B_IMM;
        case (funct3)
          3'b000:  ctl.mem_op = exu_pkg::MEM_LB;
          3'b100:  ctl.mem_op = exu_pkg::MEM_LBU;
          3'b001:  ctl.mem_op = exu_pkg::MEM_LH;
          3'b101:  ctl.mem_op = exu_pkg::MEM_LHU;
          3'b010:  ctl.mem_op = exu_pkg::MEM_LW;
          3'b110:  ctl.mem_op = exu_pkg::MEM_LWU;
          3'b011:  ctl.mem_op = exu_pkg::MEM_LD;
          default: ctl.illegal = 1'b1;
        endcase
      end
      exu_pkg::OPC_OPIMM: begin
        ctl.src_b   = exu_pkg::SRC_B_IMM;
        ctl.alu_op  = rr_alu_op(funct3, funct3 == 3'b101 && i_inst[30]);
        ctl.illegal = (funct3 == 3'b001 || funct3 == 3'b101) && !sh6_ok;
      end
      exu_pkg::OPC_OP: begin
        ctl.alu_op  = rr_alu_op(funct3, funct7[5]);
        ctl.illegal = !rr_legal;
      end
      exu_pkg::OPC_OPIMM32: begin
        ctl.word_cut = 1'b1;
        ctl.src_b    = exu_pkg::SRC_B_IMM;
        ctl.alu_op   = rr_alu_op(funct3, funct3 == 3'b101 && funct7[5]);
        ctl.illegal  = !f3_word || (funct3 != 3'b000 && !rr_legal);
      end
      exu_pkg::OPC_OP32: begin
        ctl.word_cut = 1'b1;
        ctl.alu_op   = rr_alu_op(funct3, funct7[5]);
        ctl.illegal  = !f3_word || !rr_legal;
      end
      exu_pkg::OPC_SYSTEM: begin
        if (i_inst == exu_pkg::INST_EBREAK) begin
          ctl.halt = 1'b1;
        end else if (funct3 == 3'b001) begin
          // CSRRW, new value is rs1 through the A operand
          ctl.sel_csr   = 1'b1;
          ctl.csr_write = 1'b1;
        end else begin
          ctl.illegal = 1'b1;
        end
      end
      default: ctl.illegal = 1'b1;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_push <= 1'b0;
    end else begin
      o_push <= i_inst_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      o_entry.ctl   <= ctl;
      o_entry.pc    <= i_pc;
      o_entry.rs1   <= i_rs1;
      o_entry.rs2   <= i_rs2;
      o_entry.imm   <= imm;
      o_entry.rdata <= i_rdata;
    end
  end

endmodule

`default_nettype wire

/* hw/issue_fifo.sv */
// In-order issue FIFO
`default_nettype none

module issue_fifo (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire                        i_push,
  input  wire exu_pkg::issue_entry_t i_entry,
  input  wire                        i_pop,
  output exu_pkg::issue_entry_t      o_head,
  output logic                       o_empty,
  output logic                       o_full
);

  exu_pkg::issue_entry_t mem [exu_pkg::FIFO_DEPTH];
  logic [exu_pkg::FIFO_AW:0] wr_ptr;
  logic [exu_pkg::FIFO_AW:0] rd_ptr;
  logic [exu_pkg::FIFO_AW:0] count;
  logic full;

  assign count   = wr_ptr - rd_ptr;
  assign o_empty = (wr_ptr == rd_ptr);
  // Same slot, opposite lap
  assign full    = (wr_ptr[exu_pkg::FIFO_AW] != rd_ptr[exu_pkg::FIFO_AW]) &&
                   (wr_ptr[exu_pkg::FIFO_AW-1:0] == rd_ptr[exu_pkg::FIFO_AW-1:0]);
  // The push waiting in the decoder already owns the last slot
  assign o_full  = full ||
                   (i_push && count == (exu_pkg::FIFO_AW+1)'(exu_pkg::FIFO_DEPTH - 1));
  assign o_head  = mem[rd_ptr[exu_pkg::FIFO_AW-1:0]];

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr[exu_pkg::FIFO_AW-1:0]] <= i_entry;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Source honours o_full one cycle ahead of the decoder push
  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !full
  );

  a_no_underflow: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty
  );

endmodule

`default_nettype wire

/* hw/exu_alu.sv */
// Integer ALU
`default_nettype none

module exu_alu (
  input  wire exu_pkg::xlen_t  i_src_a,
  input  wire exu_pkg::xlen_t  i_src_b,
  input  wire exu_pkg::alu_op_t i_alu_op,
  input  wire                  i_word_cut,
  output exu_pkg::xlen_t       o_result,
  output logic                 o_zero,
  output logic                 o_less,
  output logic                 o_less_u
);

  logic [64:0] diff;
  logic [31:0] sll_w;
  logic [31:0] srl_w;
  logic [31:0] sra_w;
  exu_pkg::xlen_t sra_d;
  exu_pkg::xlen_t raw;

  assign diff     = {1'b0, i_src_a} - {1'b0, i_src_b};
  assign o_zero   = (diff[63:0] == '0);
  assign o_less_u = diff[64];
  // Different signs, the negative one is smaller
  assign o_less   = (i_src_a[63] != i_src_b[63]) ? i_src_a[63] : diff[63];

  // Word shifts take 5-bit amounts
  assign sll_w = i_src_a[31:0] << i_src_b[4:0];
  assign srl_w = i_src_a[31:0] >> i_src_b[4:0];
  assign sra_w = $signed(i_src_a[31:0]) >>> i_src_b[4:0];
  assign sra_d = $signed(i_src_a) >>> i_src_b[5:0];

  always_comb begin
    case (i_alu_op)
      exu_pkg::ALU_ADD:   raw = i_src_a + i_src_b;
      exu_pkg::ALU_SUB:   raw = diff[63:0];
      exu_pkg::ALU_SLL:   raw = i_word_cut ? {32'b0, sll_w} : i_src_a << i_src_b[5:0];
      exu_pkg::ALU_SLT:   raw = {63'b0, o_less};
      exu_pkg::ALU_SLTU:  raw = {63'b0, o_less_u};
      exu_pkg::ALU_XOR:   raw = i_src_a ^ i_src_b;
      exu_pkg::ALU_SRL:   raw = i_word_cut ? {32'b0, srl_w} : i_src_a >> i_src_b[5:0];
      exu_pkg::ALU_SRA:   raw = i_word_cut ? {32'b0, sra_w} : sra_d;
      exu_pkg::ALU_OR:    raw = i_src_a | i_src_b;
      exu_pkg::ALU_AND:   raw = i_src_a & i_src_b;
      exu_pkg::ALU_COPYB: raw = i_src_b;
      default:            raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* hw/exu_branch.sv */
// Next PC logic
`default_nettype none

module exu_branch (
  input  wire exu_pkg::xlen_t i_pc,
  input  wire exu_pkg::xlen_t i_rs1,
  input  wire exu_pkg::xlen_t i_imm,
  input  wire exu_pkg::br_op_t i_br_op,
  input  wire                 i_br_unsigned,
  input  wire                 i_zero,
  input  wire                 i_less,
  input  wire                 i_less_u,
  output exu_pkg::xlen_t      o_next_pc
);

  logic lt;
  exu_pkg::xlen_t jalr_target;

  assign lt          = i_br_unsigned ? i_less_u : i_less;
  assign jalr_target = i_rs1 + i_imm;

  always_comb begin
    case (i_br_op)
      exu_pkg::BR_JAL:  o_next_pc = i_pc + i_imm;
      exu_pkg::BR_JALR: o_next_pc = {jalr_target[63:1], 1'b0};
      exu_pkg::BR_EQ:   o_next_pc = i_zero ? i_pc + i_imm : i_pc + 64'd4;
      exu_pkg::BR_NE:   o_next_pc = !i_zero ? i_pc + i_imm : i_pc + 64'd4;
      exu_pkg::BR_LT:   o_next_pc = lt ? i_pc + i_imm : i_pc + 64'd4;
      exu_pkg::BR_GE:   o_next_pc = !lt ? i_pc + i_imm : i_pc + 64'd4;
      default:          o_next_pc = i_pc + 64'd4;
    endcase
  end

endmodule

`default_nettype wire

/* hw/exu_execute.sv */
// Execute stage
`default_nettype none

module exu_execute (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire exu_pkg::issue_entry_t i_head,
  input  wire                        i_empty,
  input  wire                        i_stall,
  output logic                       o_pop,
  output logic                       o_res_valid,
  output exu_pkg::exu_result_t       o_res
);

  exu_pkg::ctl_t ctl;
  exu_pkg::xlen_t rs1_cut;
  exu_pkg::xlen_t rs2_cut;
  exu_pkg::xlen_t imm_cut;
  exu_pkg::xlen_t src_a;
  exu_pkg::xlen_t src_b;
  exu_pkg::xlen_t alu_result;
  exu_pkg::xlen_t load_data;
  exu_pkg::xlen_t next_pc;
  logic zero;
  logic less;
  logic less_u;
  exu_pkg::exu_result_t res_d;

  assign ctl   = i_head.ctl;
  assign o_pop = !i_empty && !i_stall;

  // W forms see only the low word
  assign rs1_cut = ctl.word_cut ? {32'b0, i_head.rs1[31:0]} : i_head.rs1;
  assign rs2_cut = ctl.word_cut ? {32'b0, i_head.rs2[31:0]} : i_head.rs2;
  assign imm_cut = ctl.word_cut ? {32'b0, i_head.imm[31:0]} : i_head.imm;

  assign src_a = ctl.src_a_pc ? i_head.pc : rs1_cut;

  always_comb begin
    case (ctl.src_b)
      exu_pkg::SRC_B_IMM:  src_b = imm_cut;
      exu_pkg::SRC_B_FOUR: src_b = 64'd4;
      default:             src_b = rs2_cut;
    endcase
  end

  exu_alu u_alu (
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_alu_op   (ctl.alu_op),
    .i_word_cut (ctl.word_cut),
    .o_result   (alu_result),
    .o_zero     (zero),
    .o_less     (less),
    .o_less_u   (less_u)
  );

  exu_branch u_branch (
    .i_pc          (i_head.pc),
    .i_rs1         (i_head.rs1),
    .i_imm         (i_head.imm),
    .i_br_op       (ctl.br_op),
    .i_br_unsigned (ctl.br_unsigned),
    .i_zero        (zero),
    .i_less        (less),
    .i_less_u      (less_u),
    .o_next_pc     (next_pc)
  );

  always_comb begin
    case (ctl.mem_op)
      exu_pkg::MEM_LB:  load_data = {{56{i_head.rdata[7]}}, i_head.rdata[7:0]};
      exu_pkg::MEM_LBU: load_data = {56'b0, i_head.rdata[7:0]};
      exu_pkg::MEM_LH:  load_data = {{48{i_head.rdata[15]}}, i_head.rdata[15:0]};
      exu_pkg::MEM_LHU: load_data = {48'b0, i_head.rdata[15:0]};
      exu_pkg::MEM_LW:  load_data = {{32{i_head.rdata[31]}}, i_head.rdata[31:0]};
      exu_pkg::MEM_LWU: load_data = {32'b0, i_head.rdata[31:0]};
      default:          load_data = i_head.rdata;
    endcase
  end

  always_comb begin
    if (ctl.mem_to_reg) begin
      res_d.gpr_wdata = load_data;
    end else if (ctl.sel_csr) begin
      // Old CSR value rides on rs2
      res_d.gpr_wdata = i_head.rs2;
    end else begin
      res_d.gpr_wdata = alu_result;
    end
    res_d.next_pc   = next_pc;
    res_d.csr_wdata = ctl.csr_write ? src_a : '0;
    res_d.csr_we    = ctl.csr_write;
    res_d.halt      = ctl.halt;
    res_d.illegal   = ctl.illegal;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_res_valid <= 1'b0;
      o_res       <= '0;
    end else begin
      o_res_valid <= o_pop;
      if (o_pop) begin
        o_res <= res_d;
      end
    end
  end

  // CSR write value is the whole rs1
  a_csr_from_rs1: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      o_pop && ctl.csr_write |-> !ctl.src_a_pc && !ctl.word_cut
  );

endmodule

`default_nettype wire

/* hw/exu_top.sv */
// Execute slice top level
`default_nettype none

module exu_top (
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  input  wire                   i_inst_valid,
  input  wire exu_pkg::inst_t   i_inst,
  input  wire exu_pkg::xlen_t   i_pc,
  input  wire exu_pkg::xlen_t   i_rs1,
  input  wire exu_pkg::xlen_t   i_rs2,
  input  wire exu_pkg::xlen_t   i_rdata,
  input  wire                   i_stall,
  output logic                  o_full,
  output logic                  o_res_valid,
  output exu_pkg::exu_result_t  o_res
);

  logic push;
  logic empty;
  logic pop;
  exu_pkg::issue_entry_t entry;
  exu_pkg::issue_entry_t head;

  idu_decode u_decode (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rdata      (i_rdata),
    .o_push       (push),
    .o_entry      (entry)
  );

  issue_fifo u_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (push),
    .i_entry (entry),
    .i_pop   (pop),
    .o_head  (head),
    .o_empty (empty),
    .o_full  (o_full)
  );

  exu_execute u_execute (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_head      (head),
    .i_empty     (empty),
    .i_stall     (i_stall),
    .o_pop       (pop),
    .o_res_valid (o_res_valid),
    .o_res       (o_res)
  );

endmodule

`default_nettype wire

/* bench/tb_exu_model.svh */
// Execute slice reference model
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

function automatic exu_pkg::xlen_t int_op(input logic [2:0] f3, input logic alt,
                                          input exu_pkg::xlen_t a, input exu_pkg::xlen_t b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[5:0];
    3'b010: return {63'b0, $signed(a) < $signed(b)};
    3'b011: return {63'b0, a < b};
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> b[5:0];
      end
      return a >> b[5:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic exu_pkg::xlen_t word_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
  logic [31:0] w;
  case (f3)
    3'b000: w = alt ? a - b : a + b;
    3'b001: w = a << b[4:0];
    3'b101: begin
      if (alt) begin
        w = $signed(a) >>> b[4:0];
      end else begin
        w = a >> b[4:0];
      end
    end
    default: w = '0;
  endcase
  return {{32{w[31]}}, w};
endfunction

function automatic exu_pkg::xlen_t load_ext(input logic [2:0] f3, input exu_pkg::xlen_t d);
  case (f3)
    3'b000: return {{56{d[7]}}, d[7:0]};
    3'b100: return {56'b0, d[7:0]};
    3'b001: return {{48{d[15]}}, d[15:0]};
    3'b101: return {48'b0, d[15:0]};
    3'b010: return {{32{d[31]}}, d[31:0]};
    3'b110: return {32'b0, d[31:0]};
    default: return d;
  endcase
endfunction

function automatic exu_pkg::exu_result_t exp_result(input exu_pkg::inst_t in,
    input exu_pkg::xlen_t pc_v, input exu_pkg::xlen_t rs1_v, input exu_pkg::xlen_t rs2_v,
    input exu_pkg::xlen_t rdata_v);
  exu_pkg::exu_result_t r;
  logic [2:0] f3;
  logic [6:0] f7;
  logic f7_ok;
  logic w_f3;
  logic taken;
  exu_pkg::xlen_t imm_i;
  exu_pkg::xlen_t imm_u;
  exu_pkg::xlen_t imm_j;
  exu_pkg::xlen_t imm_b;
  f3 = in[14:12];
  f7 = in[31:25];
  f7_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
  w_f3 = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101);
  taken = 1'b0;
  imm_i = {{52{in[31]}}, in[31:20]};
  imm_u = {{32{in[31]}}, in[31:12], 12'h000};
  imm_j = {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
  imm_b = {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
  r = '0;
  r.next_pc = pc_v + 64'd4;
  case (in[6:0])
    exu_pkg::OPC_LUI:   r.gpr_wdata = imm_u;
    exu_pkg::OPC_AUIPC: r.gpr_wdata = pc_v + imm_u;
    exu_pkg::OPC_JAL: begin
      r.gpr_wdata = pc_v + 64'd4;
      r.next_pc   = pc_v + imm_j;
    end
    exu_pkg::OPC_JALR: begin
      r.gpr_wdata = pc_v + 64'd4;
      r.next_pc   = (rs1_v + imm_i) & ~64'd1;
      r.illegal   = (f3 != 3'b000);
    end
    exu_pkg::OPC_BRANCH: begin
      // Writeback carries the compare subtraction
      r.gpr_wdata = rs1_v - rs2_v;
      case (f3)
        3'b000: taken = (rs1_v == rs2_v);
        3'b001: taken = (rs1_v != rs2_v);
        3'b100: taken = ($signed(rs1_v) < $signed(rs2_v));
        3'b101: taken = ($signed(rs1_v) >= $signed(rs2_v));
        3'b110: taken = (rs1_v < rs2_v);
        3'b111: taken = (rs1_v >= rs2_v);
        default: r.illegal = 1'b1;
      endcase
      if (taken) begin
        r.next_pc = pc_v + imm_b;
      end
    end
    exu_pkg::OPC_LOAD: begin
      r.gpr_wdata = load_ext(f3, rdata_v);
      r.illegal   = (f3 == 3'b111);
    end
    exu_pkg::OPC_OPIMM: begin
      r.gpr_wdata = int_op(f3, f3 == 3'b101 && in[30], rs1_v, imm_i);
      if (f3 == 3'b001) begin
        r.illegal = (in[31:26] != 6'd0);
      end else if (f3 == 3'b101) begin
        r.illegal = (in[31:26] != 6'd0) && (in[31:26] != 6'b010000);
      end
    end
    exu_pkg::OPC_OP: begin
      r.gpr_wdata = int_op(f3, f7[5], rs1_v, rs2_v);
      r.illegal   = !f7_ok;
    end
    exu_pkg::OPC_OPIMM32: begin
      r.gpr_wdata = word_op(f3, f3 == 3'b101 && f7[5], rs1_v[31:0], imm_i[31:0]);
      r.illegal   = !w_f3 || (f3 != 3'b000 && !f7_ok);
    end
    exu_pkg::OPC_OP32: begin
      r.gpr_wdata = word_op(f3, f7[5], rs1_v[31:0], rs2_v[31:0]);
      r.illegal   = !w_f3 || !f7_ok;
    end
    exu_pkg::OPC_SYSTEM: begin
      if (in == 32'h0010_0073) begin
        r.halt = 1'b1;
      end else if (f3 == 3'b001) begin
        r.gpr_wdata = rs2_v;
        r.csr_wdata = rs1_v;
        r.csr_we    = 1'b1;
      end else begin
        r.illegal = 1'b1;
      end
    end
    default: r.illegal = 1'b1;
  endcase
  return r;
endfunction

`endif

/* bench/tb_exu_top.sv */
// Execute slice testbench
`default_nettype none

module tb_exu_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;
  localparam int ALU_ROUNDS = 3;
  localparam int STALL_HOLD = 8;
  // Instructions issued over all tests, rounded up
  localparam int N_INST = ALU_ROUNDS * 30 + 22 + 14 + 5 + exu_pkg::FIFO_DEPTH;

  logic clk;
  logic rst_n;
  logic inst_valid;
  exu_pkg::inst_t inst;
  exu_pkg::xlen_t pc;
  exu_pkg::xlen_t rs1;
  exu_pkg::xlen_t rs2;
  exu_pkg::xlen_t rdata;
  logic stall;
  logic full;
  logic res_valid;
  exu_pkg::exu_result_t res;

  exu_pkg::exu_result_t exp_q[$];
  integer seed = 7431;
  int cmp_errors = 0;
  int seq_errors = 0;
  int n_valid = 0;

  `include "tb_exu_model.svh"

  exu_top DUT (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .i_pc         (pc),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rdata      (rdata),
    .i_stall      (stall),
    .o_full       (full),
    .o_res_valid  (res_valid),
    .o_res        (res)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  function automatic exu_pkg::xlen_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic exu_pkg::inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [6:0] opc);
    return {f7, 5'd7, 5'd6, f3, 5'd5, opc};
  endfunction

  function automatic exu_pkg::inst_t i_type(input logic [11:0] imm, input logic [2:0] f3,
                                            input logic [6:0] opc);
    return {imm, 5'd6, f3, 5'd5, opc};
  endfunction

  function automatic exu_pkg::inst_t b_type(input logic [12:0] off, input logic [2:0] f3);
    return {off[12], off[10:5], 5'd7, 5'd6, f3, off[4:1], off[11], exu_pkg::OPC_BRANCH};
  endfunction

  function automatic exu_pkg::inst_t j_type(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, exu_pkg::OPC_JAL};
  endfunction

  // Called on a falling edge, returns on the next one
  task automatic issue(input exu_pkg::inst_t in, input exu_pkg::xlen_t rs1_v,
                       input exu_pkg::xlen_t rs2_v, input exu_pkg::xlen_t rdata_v);
    exu_pkg::xlen_t pc_v;
    pc_v = rand64() & ~64'd3;
    while (full) begin
      @(negedge clk);
    end
    inst_valid = 1'b1;
    inst = in;
    pc = pc_v;
    rs1 = rs1_v;
    rs2 = rs2_v;
    rdata = rdata_v;
    exp_q.push_back(exp_result(in, pc_v, rs1_v, rs2_v, rdata_v));
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic check_reset_state();
    repeat (3) begin
      if (res_valid !== 1'b0 || full !== 1'b0) begin
        $display("** Error: %0t: o_res_valid %b o_full %b before the first push",
                 $time, res_valid, full);
        seq_errors++;
      end
      if (res !== '0) begin
        $display("** Error: %0t: o_res %h not zero after reset", $time, res);
        seq_errors++;
      end
      @(negedge clk);
    end
  endtask

  task automatic alu_round();
    int k;
    logic [2:0] f3;
    logic [11:0] imm;
    for (k = 0; k < 8; k++) begin
      f3 = 3'(k);
      issue(r_type(7'h00, f3, exu_pkg::OPC_OP), rand64(), rand64(), 64'd0);
      imm = 12'($random(seed));
      // Shift immediates keep funct6 zero
      if (f3 == 3'b001 || f3 == 3'b101) begin
        imm[11:6] = 6'd0;
      end
      issue(i_type(imm, f3, exu_pkg::OPC_OPIMM), rand64(), rand64(), 64'd0);
    end
    issue(r_type(7'h20, 3'b000, exu_pkg::OPC_OP), rand64(), rand64(), 64'd0);
    issue(r_type(7'h20, 3'b101, exu_pkg::OPC_OP), rand64(), rand64(), 64'd0);
    issue(i_type({6'b010000, 6'($random(seed))}, 3'b101, exu_pkg::OPC_OPIMM),
          rand64(), rand64(), 64'd0);
    issue(r_type(7'h00, 3'b000, exu_pkg::OPC_OP32), rand64(), rand64(), 64'd0);
    issue(r_type(7'h20, 3'b000, exu_pkg::OPC_OP32), rand64(), rand64(), 64'd0);
    issue(r_type(7'h00, 3'b001, exu_pkg::OPC_OP32), rand64(), rand64(), 64'd0);
    issue(r_type(7'h00, 3'b101, exu_pkg::OPC_OP32), rand64(), rand64(), 64'd0);
    issue(r_type(7'h20, 3'b101, exu_pkg::OPC_OP32), rand64(), rand64(), 64'd0);
    issue(i_type(12'($random(seed)), 3'b000, exu_pkg::OPC_OPIMM32),
          rand64(), rand64(), 64'd0);
    issue(i_type({7'h00, 5'($random(seed))}, 3'b001, exu_pkg::OPC_OPIMM32),
          rand64(), rand64(), 64'd0);
    issue(i_type({7'h00, 5'($random(seed))}, 3'b101, exu_pkg::OPC_OPIMM32),
          rand64(), rand64(), 64'd0);
    issue(i_type({7'h20, 5'($random(seed))}, 3'b101, exu_pkg::OPC_OPIMM32),
          rand64(), rand64(), 64'd0);
    issue({20'($random(seed)), 5'd5, exu_pkg::OPC_LUI}, rand64(), rand64(), 64'd0);
    issue({20'($random(seed)), 5'd5, exu_pkg::OPC_AUIPC}, rand64(), rand64(), 64'd0);
  endtask

  task automatic branch_tests();
    int k;
    logic [2:0] f3;
    logic [12:0] off;
    exu_pkg::xlen_t x;
    exu_pkg::xlen_t y;
    for (k = 0; k < 6; k++) begin
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      x = rand64();
      y = rand64();
      off = {12'($random(seed)), 1'b0};
      // Equal pair and both orders give taken and not taken for each kind
      issue(b_type(off, f3), x, x, 64'd0);
      issue(b_type(off, f3), x, y, 64'd0);
      issue(b_type(off, f3), y, x, 64'd0);
    end
    issue(j_type({20'($random(seed)), 1'b0}), rand64(), rand64(), 64'd0);
    issue(j_type({20'($random(seed)), 1'b0}), rand64(), rand64(), 64'd0);
    issue(i_type(12'($random(seed)), 3'b000, exu_pkg::OPC_JALR), rand64(), rand64(), 64'd0);
    issue(i_type(12'($random(seed)), 3'b000, exu_pkg::OPC_JALR), rand64(), rand64(), 64'd0);
  endtask

  task automatic load_tests();
    int k;
    for (k = 0; k < 14; k++) begin
      issue(i_type(12'($random(seed)), 3'(k % 7), exu_pkg::OPC_LOAD),
            rand64(), rand64(), rand64());
    end
  endtask

  task automatic system_tests();
    issue(i_type(12'($random(seed)), 3'b001, exu_pkg::OPC_SYSTEM), rand64(), rand64(), 64'd0);
    issue(i_type(12'($random(seed)), 3'b001, exu_pkg::OPC_SYSTEM), rand64(), rand64(), 64'd0);
    issue(32'h0010_0073, rand64(), rand64(), 64'd0);
    issue({25'($random(seed)), 7'b0101111}, rand64(), rand64(), 64'd0);
    // Multiply is outside RV64I
    issue(r_type(7'h01, 3'b000, exu_pkg::OPC_OP), rand64(), rand64(), 64'd0);
  endtask

  task automatic stall_test();
    int k;
    int seen;
    wait_idle();
    stall = 1'b1;
    seen = n_valid;
    for (k = 0; k < exu_pkg::FIFO_DEPTH; k++) begin
      if (full !== 1'b0) begin
        $display("** Error: %0t: o_full high after %0d pushes", $time, k);
        seq_errors++;
      end
      issue(r_type(7'h00, 3'b000, exu_pkg::OPC_OP), rand64(), rand64(), 64'd0);
    end
    repeat (STALL_HOLD) begin
      if (full !== 1'b1) begin
        $display("** Error: %0t: o_full low with %0d entries held", $time,
                 exu_pkg::FIFO_DEPTH);
        seq_errors++;
      end
      @(negedge clk);
    end
    if (n_valid != seen) begin
      $display("** Error: %0t: %0d results appeared under stall", $time, n_valid - seen);
      seq_errors++;
    end
    stall = 1'b0;
    wait_idle();
  endtask

  initial begin
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    rs1 = '0;
    rs2 = '0;
    rdata = '0;
    stall = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    repeat (ALU_ROUNDS) alu_round();
    branch_tests();
    load_tests();
    system_tests();
    stall_test();
    wait_idle();
    $display("Results checked: %0d, errors: %0d", n_valid, cmp_errors + seq_errors);
    if (cmp_errors + seq_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(negedge clk) begin
    exu_pkg::exu_result_t want;
    if (rst_n && res_valid) begin
      n_valid++;
      if (exp_q.size() == 0) begin
        $display("Result %0d arrived at %0t with no instruction outstanding", n_valid, $time);
        cmp_errors++;
      end else begin
        want = exp_q.pop_front();
        // Writeback of a halting or illegal instruction is undefined
        if (!want.halt && !want.illegal && res.gpr_wdata !== want.gpr_wdata) begin
          $display("** Error: %0t: result %0d gpr_wdata %h, expected %h",
                   $time, n_valid, res.gpr_wdata, want.gpr_wdata);
          cmp_errors++;
        end
        if (res.next_pc !== want.next_pc) begin
          $display("** Error: %0t: result %0d next_pc %h, expected %h",
                   $time, n_valid, res.next_pc, want.next_pc);
          cmp_errors++;
        end
        if (res.csr_wdata !== want.csr_wdata) begin
          $display("** Error: %0t: result %0d csr_wdata %h, expected %h",
                   $time, n_valid, res.csr_wdata, want.csr_wdata);
          cmp_errors++;
        end
        if (res.csr_we !== want.csr_we) begin
          $display("** Error: %0t: result %0d csr_we %b, expected %b",
                   $time, n_valid, res.csr_we, want.csr_we);
          cmp_errors++;
        end
        if (res.halt !== want.halt) begin
          $display("** Error: %0t: result %0d halt %b, expected %b",
                   $time, n_valid, res.halt, want.halt);
          cmp_errors++;
        end
        if (res.illegal !== want.illegal) begin
          $display("** Error: %0t: result %0d illegal %b, expected %b",
                   $time, n_valid, res.illegal, want.illegal);
          cmp_errors++;
        end
      end
    end
  end

  // Forty cycles per instruction plus the stall window
  initial begin
    #((N_INST * 40 + STALL_HOLD + 20) * CLK_PERIOD);
    $display("Timeout: run did not finish, %0d results still outstanding", exp_q.size());
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
hw/exu_pkg.sv
hw/idu_decode.sv
hw/issue_fifo.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_execute.sv
hw/exu_top.sv
bench/tb_exu_top.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_exu_top -f build.f --Mdir obj_dir -o Vtb_exu_top

run: compile
	./obj_dir/Vtb_exu_top | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
